// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import rv64_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  fetch_t    fetched,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output decode_t   decoded
);

  instr_u instr;
  ctrl_t  ctrl;
  word_t  imm;

  assign instr = fetched.instr;

  // Register fields sit at the same place in every format that has them
  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;

  // Immediate by format, sign-extended to xlen
  always_comb begin
    case (instr.r.opcode)
      op_store:  imm = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      op_branch: imm = {{(xlen-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                        instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      op_jal:    imm = {{(xlen-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                        instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      default:   imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};  // I-type
    endcase
  end

  always_comb begin
    ctrl = '0;  // Anything unsupported retires with no effect
    case (instr.r.opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
        case (instr.r.funct3)
          f3_add_sub: ctrl.alu_op = (instr.r.funct7 == f7_alt) ? alu_sub : alu_add;
          f3_sll:     ctrl.alu_op = alu_sll;
          f3_xor:     ctrl.alu_op = alu_xor;
          f3_srl_sra: ctrl.alu_op = (instr.r.funct7 == f7_alt) ? alu_sra : alu_srl;
          f3_or:      ctrl.alu_op = alu_or;
          f3_and:     ctrl.alu_op = alu_and;
          default:    ctrl = '0;  // SLT/SLTU
        endcase
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        case (instr.i.funct3)
          f3_add_sub: ctrl.alu_op = alu_add;
          f3_sll:     ctrl.alu_op = alu_sll;
          f3_xor:     ctrl.alu_op = alu_xor;
          f3_srl_sra: ctrl.alu_op = instr.i.imm[10] ? alu_sra : alu_srl;  // funct6 bit
          f3_or:      ctrl.alu_op = alu_or;
          f3_and:     ctrl.alu_op = alu_and;
          default:    ctrl = '0;
        endcase
      end
      op_load: begin
        if (instr.i.funct3 == f3_double) begin
          ctrl.is_load   = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.use_imm   = 1'b1;  // Address = rs1 + imm
        end
      end
      op_store: begin
        if (instr.s.funct3 == f3_double) begin
          ctrl.is_store = 1'b1;
          ctrl.use_imm  = 1'b1;
        end
      end
      op_branch: begin
        if (instr.b.funct3 == f3_beq || instr.b.funct3 == f3_bne) begin
          ctrl.is_branch = 1'b1;
          ctrl.branch_ne = (instr.b.funct3 == f3_bne);
        end
      end
      op_jal: begin
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;  // Link register
      end
      default: ;
    endcase
  end

  // Decode stage register
  always_ff @(posedge clk) begin
    if (reset) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= fetched.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetched.valid) begin
      decoded.pc      <= fetched.pc;
      decoded.ctrl    <= ctrl;
      decoded.rs1_val <= rs1_data;  // Register file reads are combinational
      decoded.rs2_val <= rs2_data;
      decoded.imm     <= imm;
      decoded.rd      <= instr.r.rd;
    end
  end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import rv64_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  decode_t decoded,
  output exec_t   executed
);

  word_t      op_a;
  word_t      op_b;
  logic [5:0] shamt;
  word_t      alu_out;
  word_t      pc_plus4;
  word_t      pc_target;
  logic       taken;
  word_t      next_pc;
  word_t      result;

  assign op_a  = decoded.rs1_val;
  assign op_b  = decoded.ctrl.use_imm ? decoded.imm : decoded.rs2_val;
  assign shamt = op_b[5:0];  // RV64 shifts use six bits

  always_comb begin
    case (decoded.ctrl.alu_op)
      alu_add: alu_out = op_a + op_b;
      alu_sub: alu_out = op_a - op_b;
      alu_and: alu_out = op_a & op_b;
      alu_or:  alu_out = op_a | op_b;
      alu_xor: alu_out = op_a ^ op_b;
      alu_sll: alu_out = op_a << shamt;
      alu_srl: alu_out = op_a >> shamt;
      alu_sra: alu_out = word_t'($signed(op_a) >>> shamt);
      default: alu_out = '0;
    endcase
  end

  // Branch compare always on the two register values
  assign taken = decoded.ctrl.is_branch &&
                 ((decoded.rs1_val == decoded.rs2_val) ^ decoded.ctrl.branch_ne);

  assign pc_plus4  = decoded.pc + 64'd4;
  assign pc_target = decoded.pc + decoded.imm;

  // Redirect on taken branch or JAL
  assign next_pc = (taken || decoded.ctrl.is_jal) ? pc_target : pc_plus4;

  // JAL writes the return address
  assign result = decoded.ctrl.is_jal ? pc_plus4 : alu_out;

  // Execute stage register
  always_ff @(posedge clk) begin
    if (reset) begin
      executed.valid <= 1'b0;
    end else begin
      executed.valid <= decoded.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (decoded.valid) begin
      executed.pc         <= decoded.pc;
      executed.ctrl       <= decoded.ctrl;
      executed.result     <= result;
      executed.store_data <= decoded.rs2_val;
      executed.next_pc    <= next_pc;
      executed.rd         <= decoded.rd;
    end
  end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage import rv64_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  word_t       entry,
  input  logic [31:0] imem_rdata,
  input  retire_t     retire,
  output logic        imem_req,
  output word_t       imem_addr,
  output fetch_t      fetched
);

  word_t pc;
  logic  idle;  // Nothing issued since reset
  logic  req;

  // PC follows the retiring instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= entry;
    end else if (retire.valid) begin
      pc <= retire.next_pc;
    end
  end

  // One request after reset, then one per retirement
  always_ff @(posedge clk) begin
    if (reset) begin
      idle <= 1'b1;
      req  <= 1'b0;
    end else begin
      idle <= 1'b0;
      req  <= idle || retire.valid;  // Single-cycle pulse
    end
  end

  assign imem_req  = req;
  assign imem_addr = pc;

  // Fetch stage register
  always_ff @(posedge clk) begin
    if (reset) begin
      fetched.valid <= 1'b0;
    end else begin
      fetched.valid <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      fetched.pc    <= pc;
      fetched.instr <= imem_rdata;  // Port answers in the request cycle
    end
  end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage import rv64_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  exec_t     executed,
  input  word_t     dmem_rdata,
  output dmem_req_t dmem,
  output retire_t   retire
);

  word_t wb_data;

  // Data port request, one cycle per load or store
  assign dmem.strobe = executed.valid && (executed.ctrl.is_load || executed.ctrl.is_store);
  assign dmem.write  = executed.ctrl.is_store;
  assign dmem.addr   = executed.result;  // Effective address from the ALU
  assign dmem.wdata  = executed.store_data;

  // Writeback select
  assign wb_data = executed.ctrl.is_load ? dmem_rdata : executed.result;

  // Retire register
  always_ff @(posedge clk) begin
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= executed.valid;  // One-cycle pulse per instruction
    end
  end

  always_ff @(posedge clk) begin
    if (executed.valid) begin
      retire.pc        <= executed.pc;
      retire.reg_write <= executed.ctrl.reg_write;
      retire.rd        <= executed.rd;
      retire.data      <= wb_data;
      retire.next_pc   <= executed.next_pc;
    end
  end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/100ps

module register_file import rv64_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  word_t     stackptr,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  retire_t   retire,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [reg_count];

  logic wr_en;

  // Write port driven straight from the retire entry
  assign wr_en = retire.valid && retire.reg_write && (retire.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
      regs[2] <= stackptr;  // sp starts at the given stack top
    end else if (wr_en) begin
      regs[retire.rd] <= retire.data;
    end
  end

  // x0 always reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== logic/rv64_core.sv ====
`timescale 1ns/100ps

module rv64_core import rv64_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  word_t       entry,     // Reset PC
  input  word_t       stackptr,  // Initial x2
  input  logic [31:0] imem_rdata,
  input  word_t       dmem_rdata,
  output logic        imem_req,
  output word_t       imem_addr,
  output dmem_req_t   dmem,
  output retire_t     retire
);

  fetch_t    fetched;
  decode_t   decoded;
  exec_t     executed;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  register_file u_register_file (
    .clk      (clk),
    .reset    (reset),
    .stackptr (stackptr),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .retire   (retire),  // Writeback
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // Retire entry also restarts fetch
  fetch_stage u_fetch_stage (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry),
    .imem_rdata (imem_rdata),
    .retire     (retire),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .fetched    (fetched)
  );

  decode_stage u_decode_stage (
    .clk      (clk),
    .reset    (reset),
    .fetched  (fetched),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .decoded  (decoded)
  );

  execute_stage u_execute_stage (
    .clk      (clk),
    .reset    (reset),
    .decoded  (decoded),
    .executed (executed)
  );

  memory_stage u_memory_stage (
    .clk        (clk),
    .reset      (reset),
    .executed   (executed),
    .dmem_rdata (dmem_rdata),
    .dmem       (dmem),
    .retire     (retire)
  );

endmodule

// ==== logic/rv64_pkg.sv ====
package rv64_pkg;

  localparam int xlen       = 64;
  localparam int reg_count  = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes of the supported subset
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  localparam logic [2:0] f3_add_sub = 3'b000;  // ADD/SUB/ADDI
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_double  = 3'b011;  // LD/SD width
  localparam logic [6:0] f7_alt     = 7'b0100000;  // SUB and SRA select

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra
  } alu_op_e;

  // Instruction formats, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One word, five views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;    // Operand B from immediate
    logic    reg_write;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    branch_ne;  // BNE when set, BEQ otherwise
    logic    is_jal;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    word_t       pc;
    logic [31:0] instr;
  } fetch_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    ctrl_t     ctrl;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_addr_t rd;
  } decode_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    ctrl_t     ctrl;
    word_t     result;      // ALU result, load/store address or link value
    word_t     store_data;
    word_t     next_pc;
    reg_addr_t rd;
  } exec_t;

  typedef struct packed {
    logic  strobe;
    logic  write;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
    word_t     next_pc;
  } retire_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; a $fatal gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f rv64_core.f --top-module rv64_core_tb &&
./obj_dir/Vrv64_core_tb ||
{
  echo "rv64_core simulation failed"
  exit 1
}

// ==== rv64_core.f ====
logic/rv64_pkg.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv64_core.sv
tests/rv64_ref_model.sv
tests/rv64_core_tb.sv

// ==== tests/rv64_core_tb.sv ====
`timescale 1ns/100ps

module rv64_core_tb import rv64_pkg::*; ();

  localparam int prog_len      = 32;
  localparam int retire_target = 32;  // 29 on the program path, then the final self-loop
  localparam int watchdog_ns   = (retire_target * 5 + 20) * 4;

  logic        clk = 1'b0;
  logic        reset;
  word_t       entry_val;
  word_t       stackptr_val;
  logic [31:0] imem_rdata;
  word_t       dmem_rdata;
  logic        imem_req;
  word_t       imem_addr;
  dmem_req_t   dmem;
  retire_t     retire;

  logic [31:0] prog [prog_len];
  word_t       dmem_words [word_t];  // Sparse data memory
  word_t       ref_pc;
  logic [31:0] ref_instr;
  retire_t     pred_retire;
  dmem_req_t   pred_mem;
  int          retire_count = 0;

  always #2 clk = ~clk;

  rv64_core dut (
    .clk        (clk),
    .reset      (reset),
    .entry      (entry_val),
    .stackptr   (stackptr_val),
    .imem_rdata (imem_rdata),
    .dmem_rdata (dmem_rdata),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .dmem       (dmem),
    .retire     (retire)
  );

  rv64_ref_model u_ref_model (
    .clk      (clk),
    .reset    (reset),
    .entry    (entry_val),
    .stackptr (stackptr_val),
    .step     (retire.valid),
    .instr    (ref_instr),
    .pc       (ref_pc),
    .pred     (pred_retire),
    .pred_mem (pred_mem)
  );

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3_double, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // Program image starts at entry, outside it reads as zero
  function automatic logic [31:0] fetch_word(word_t addr);
    word_t idx;
    idx = (addr - entry_val) >> 2;
    return (idx < prog_len) ? prog[idx[4:0]] : 32'h0;
  endfunction

  function automatic word_t read_data(word_t addr);
    return dmem_words.exists(addr) ? dmem_words[addr] : ~addr;  // Unwritten word is ~address
  endfunction

  always_comb imem_rdata = fetch_word(imem_addr);  // Same-cycle answer
  always_comb dmem_rdata = read_data(dmem.addr);
  always_comb ref_instr  = fetch_word(ref_pc);

  always @(posedge clk) begin
    if (!reset && dmem.strobe && dmem.write) begin
      dmem_words[dmem.addr] = dmem.wdata;
    end
    if (retire.valid) begin
      retire_count <= retire_count + 1;
    end
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(string name, word_t got, word_t want);
    fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  // Nothing leaves the core while reset is held
  assert property (@(posedge clk) $past(reset) |-> !imem_req && !dmem.strobe && !retire.valid)
    else fail_run("imem_req, dmem strobe or retire valid seen during reset");
  assert property (@(posedge clk) disable iff (reset) imem_req |-> imem_addr == ref_pc)
    else report_mismatch("imem_addr", $sampled(imem_addr), $sampled(ref_pc));
  assert property (@(posedge clk) disable iff (reset) imem_req |-> ##4 retire.valid)
    else fail_run("retire valid did not come 4 cycles after imem_req");
  assert property (@(posedge clk) disable iff (reset) retire.valid |=> imem_req)
    else fail_run("imem_req did not come 1 cycle after retire valid");
  // Data access lands in cycle 3 of the instruction
  assert property (@(posedge clk) disable iff (reset)
                   imem_req |-> ##3 dmem.strobe == pred_mem.strobe)
    else fail_run("dmem strobe wrong in the memory cycle");
  assert property (@(posedge clk) disable iff (reset) dmem.strobe |-> dmem.write == pred_mem.write)
    else report_mismatch("dmem.write", word_t'($sampled(dmem.write)),
                         word_t'($sampled(pred_mem.write)));
  assert property (@(posedge clk) disable iff (reset) dmem.strobe |-> dmem.addr == pred_mem.addr)
    else report_mismatch("dmem.addr", $sampled(dmem.addr), $sampled(pred_mem.addr));
  assert property (@(posedge clk) disable iff (reset)
                   dmem.strobe && dmem.write |-> dmem.wdata == pred_mem.wdata)
    else report_mismatch("dmem.wdata", $sampled(dmem.wdata), $sampled(pred_mem.wdata));
  assert property (@(posedge clk) disable iff (reset) retire.valid |-> retire.pc == pred_retire.pc)
    else report_mismatch("retire.pc", $sampled(retire.pc), $sampled(pred_retire.pc));
  assert property (@(posedge clk) disable iff (reset)
                   retire.valid |-> retire.reg_write == pred_retire.reg_write)
    else report_mismatch("retire.reg_write", word_t'($sampled(retire.reg_write)),
                         word_t'($sampled(pred_retire.reg_write)));
  assert property (@(posedge clk) disable iff (reset)
                   retire.valid && pred_retire.reg_write |-> retire.rd == pred_retire.rd)
    else report_mismatch("retire.rd", word_t'($sampled(retire.rd)),
                         word_t'($sampled(pred_retire.rd)));
  assert property (@(posedge clk) disable iff (reset)
                   retire.valid && pred_retire.reg_write |-> retire.data == pred_retire.data)
    else report_mismatch("retire.data", $sampled(retire.data), $sampled(pred_retire.data));
  assert property (@(posedge clk) disable iff (reset)
                   retire.valid |-> retire.next_pc == pred_retire.next_pc)
    else report_mismatch("retire.next_pc", $sampled(retire.next_pc),
                         $sampled(pred_retire.next_pc));

  initial begin
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    logic [11:0] off;
    logic [5:0]  sh;
    void'($urandom(64459));
    imm_a        = 12'($urandom);
    imm_b        = 12'($urandom);
    imm_c        = 12'($urandom);
    off          = 12'($urandom) & 12'h7f8;  // Doubleword aligned, positive
    sh           = 6'($urandom);
    entry_val    = {$urandom, $urandom} & ~64'h3;
    stackptr_val = {$urandom, $urandom} & ~64'h7;
    reset        = 1'b1;
    prog[0]  = enc_i(op_imm, f3_add_sub, 5'd5, 5'd2, imm_a);  // Reads x2 before any write
    prog[1]  = enc_i(op_imm, f3_add_sub, 5'd6, 5'd0, imm_b);
    prog[2]  = enc_r(7'd0, f3_add_sub, 5'd7, 5'd5, 5'd6);
    prog[3]  = enc_r(f7_alt, f3_add_sub, 5'd8, 5'd5, 5'd6);
    prog[4]  = enc_r(7'd0, f3_and, 5'd9, 5'd7, 5'd8);
    prog[5]  = enc_r(7'd0, f3_or, 5'd10, 5'd7, 5'd8);
    prog[6]  = enc_r(7'd0, f3_xor, 5'd11, 5'd7, 5'd8);
    prog[7]  = enc_r(7'd0, f3_sll, 5'd12, 5'd7, 5'd6);
    prog[8]  = enc_r(7'd0, f3_srl_sra, 5'd13, 5'd8, 5'd6);
    prog[9]  = enc_r(f7_alt, f3_srl_sra, 5'd14, 5'd8, 5'd6);
    prog[10] = enc_i(op_imm, f3_and, 5'd15, 5'd11, imm_c);
    prog[11] = enc_i(op_imm, f3_or, 5'd16, 5'd11, imm_c);
    prog[12] = enc_i(op_imm, f3_xor, 5'd17, 5'd11, imm_c);
    prog[13] = enc_i(op_imm, f3_sll, 5'd18, 5'd7, {6'b000000, sh});
    prog[14] = enc_i(op_imm, f3_srl_sra, 5'd19, 5'd8, {6'b000000, sh});
    prog[15] = enc_i(op_imm, f3_srl_sra, 5'd20, 5'd8, {6'b010000, sh});
    prog[16] = enc_i(op_imm, f3_add_sub, 5'd0, 5'd7, imm_a);   // Write to x0 is dropped
    prog[17] = enc_r(7'd0, f3_add_sub, 5'd21, 5'd0, 5'd7);     // x0 operand reads zero
    prog[18] = enc_s(5'd11, 5'd2, off);
    prog[19] = enc_i(op_load, f3_double, 5'd22, 5'd2, off);    // Reads back the stored word
    prog[20] = enc_b(f3_beq, 5'd22, 5'd11, 13'd8);             // Taken
    prog[21] = enc_i(op_imm, f3_add_sub, 5'd23, 5'd0, 12'd1);  // Skipped
    prog[22] = enc_b(f3_bne, 5'd22, 5'd11, 13'd8);             // Not taken
    prog[23] = enc_i(op_imm, f3_add_sub, 5'd24, 5'd0, 12'd1);
    prog[24] = enc_b(f3_beq, 5'd24, 5'd0, 13'd8);              // Not taken
    prog[25] = enc_b(f3_bne, 5'd24, 5'd0, 13'd8);              // Taken
    prog[26] = enc_i(op_imm, f3_add_sub, 5'd25, 5'd0, 12'd2);  // Skipped
    prog[27] = enc_j(5'd1, 21'd8);
    prog[28] = enc_i(op_imm, f3_add_sub, 5'd26, 5'd0, 12'd3);  // Skipped
    prog[29] = enc_r(7'd0, f3_add_sub, 5'd27, 5'd1, 5'd24);    // Uses the link value
    prog[30] = 32'h1234_5037;                                  // LUI, retires as a no-op
    prog[31] = enc_j(5'd0, 21'd0);                             // Park on a self-loop
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    wait (retire_count >= retire_target);
    @(posedge clk);
    $display("** PASS **");
    $finish;
  end

  // Watchdog sized from the retirements the program needs
  initial begin
    #(watchdog_ns);
    fail_run("watchdog expired, the core stopped retiring instructions");
  end

endmodule

// ==== tests/rv64_ref_model.sv ====
`timescale 1ns/100ps

module rv64_ref_model import rv64_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  word_t       entry,
  input  word_t       stackptr,
  input  logic        step,      // One retirement per pulse
  input  logic [31:0] instr,     // Program word at pc
  output word_t       pc,
  output retire_t     pred,
  output dmem_req_t   pred_mem
);

  word_t x [32];
  word_t mem [word_t];  // Words stored so far
  word_t rs1_v;
  word_t rs2_v;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;

  // Integer ALU as the ISA defines it
  function automatic word_t alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  always_comb begin
    rs1_v = x[instr[19:15]];
    rs2_v = x[instr[24:20]];
    imm_i = {{52{instr[31]}}, instr[31:20]};
    imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    pred         = '0;
    pred_mem     = '0;
    pred.valid   = 1'b1;
    pred.pc      = pc;
    pred.rd      = instr[11:7];
    pred.next_pc = pc + 64'd4;  // Sequential unless redirected below
    case (instr[6:0])
      7'b0110011: begin
        pred.reg_write = (instr[14:13] != 2'b01);  // SLT and SLTU retire as no-ops
        pred.data      = alu(instr[14:12], instr[30], rs1_v, rs2_v);
      end
      7'b0010011: begin
        // Bit 30 selects SRAI only since ADDI has no SUB form
        pred.reg_write = (instr[14:13] != 2'b01);  // SLTI and SLTIU retire as no-ops
        pred.data      = alu(instr[14:12], (instr[14:12] == 3'b101) && instr[30], rs1_v, imm_i);
      end
      7'b0000011: begin
        if (instr[14:12] == 3'b011) begin
          pred_mem.strobe = 1'b1;
          pred_mem.addr   = rs1_v + imm_i;
          pred.reg_write  = 1'b1;
          pred.data = mem.exists(pred_mem.addr) ? mem[pred_mem.addr] : ~pred_mem.addr;
        end
      end
      7'b0100011: begin
        if (instr[14:12] == 3'b011) begin
          pred_mem.strobe = 1'b1;
          pred_mem.write  = 1'b1;
          pred_mem.addr   = rs1_v + imm_s;
          pred_mem.wdata  = rs2_v;
        end
      end
      7'b1100011: begin
        // BEQ taken on equal and BNE on not equal
        if (instr[14:13] == 2'b00 && ((rs1_v == rs2_v) != instr[12])) begin
          pred.next_pc = pc + imm_b;
        end
      end
      7'b1101111: begin
        pred.reg_write = 1'b1;
        pred.data      = pc + 64'd4;  // Link value
        pred.next_pc   = pc + imm_j;
      end
      default: ;  // Anything else changes nothing
    endcase
  end

  always @(posedge clk) begin
    if (reset) begin
      pc <= entry;
      for (int i = 0; i < 32; i++) begin
        x[i] <= (i == 2) ? stackptr : '0;
      end
    end else if (step) begin
      if (pred.reg_write && pred.rd != 5'd0) begin
        x[pred.rd] <= pred.data;  // x0 stays zero
      end
      if (pred_mem.strobe && pred_mem.write) begin
        mem[pred_mem.addr] = pred_mem.wdata;
      end
      pc <= pred.next_pc;
    end
  end

endmodule
